// ==== Bender.yml ====
package:
  name: maze_game

sources:
  - files:
      - design/maze_pkg.sv
      - design/game_sequencer.sv
      - design/draw_queue.sv
      - design/sprite_plotter.sv
      - design/countdown_timer.sv
      - design/seconds_display.sv
      - design/maze_game_top.sv
  - target: test
    files:
      - tb/maze_game_assert.sv
      - tb/tb_maze_game.sv

// ==== design/countdown_timer.sv ====
`timescale 1ns/10ps

module countdown_timer #(
    parameter int TICK_CYCLES = maze_pkg::TICK_CYCLES_DEFAULT
) (
    input  logic               Clk,
    input  logic               resetn,
    input  logic               playing,
    output maze_pkg::seconds_t seconds,
    output logic               timeout
);
    import maze_pkg::*;

    localparam int PRE_W = $clog2(TICK_CYCLES + 1);

    logic [PRE_W-1:0] pre_cnt;
    logic             tick;

    assign tick = playing && (pre_cnt == PRE_W'(TICK_CYCLES - 1));

    // One second prescaler that restarts whenever play stops
    always_ff @(posedge Clk)
    begin
        if (!resetn)
            pre_cnt <= '0;
        else if (!playing || tick)
            pre_cnt <= '0;
        else
            pre_cnt <= pre_cnt + 1'b1;
    end

    always_ff @(posedge Clk)
    begin
        if (!resetn)
        begin
            seconds <= seconds_t'(GAME_SECONDS);
            timeout <= 1'b0;
        end
        else if (tick && seconds != '0)
        begin
            seconds <= seconds - 1'b1;
            if (seconds == seconds_t'(1))
                timeout <= 1'b1;   // Sticky until reset
        end
    end

endmodule

// ==== design/draw_queue.sv ====
`timescale 1ns/10ps

module draw_queue (
    input  logic                  Clk,
    input  logic                  resetn,
    input  logic                  in_valid,
    input  maze_pkg::draw_layer_t in_layer,
    input  maze_pkg::coord_x_t    in_x,
    input  maze_pkg::coord_y_t    in_y,
    input  logic                  out_ready,
    output logic                  in_ready,
    output logic                  out_valid,
    output maze_pkg::draw_layer_t out_layer,
    output maze_pkg::coord_x_t    out_x,
    output maze_pkg::coord_y_t    out_y
);
    import maze_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    draw_layer_t  layer_mem [QUEUE_DEPTH];
    coord_x_t     x_mem     [QUEUE_DEPTH];
    coord_y_t     y_mem     [QUEUE_DEPTH];
    logic [PTR_W:0] wr_ptr;   // Extra bit tells full from empty
    logic [PTR_W:0] rd_ptr;
    logic         push;
    logic         pop;
    logic         full;
    logic         empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge Clk)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (push)
        begin
            layer_mem[wr_ptr[PTR_W-1:0]] <= in_layer;
            x_mem[wr_ptr[PTR_W-1:0]]     <= in_x;
            y_mem[wr_ptr[PTR_W-1:0]]     <= in_y;
        end
    end

    // Head entry shown directly
    assign out_layer = layer_mem[rd_ptr[PTR_W-1:0]];
    assign out_x     = x_mem[rd_ptr[PTR_W-1:0]];
    assign out_y     = y_mem[rd_ptr[PTR_W-1:0]];

endmodule

// ==== design/game_sequencer.sv ====
`timescale 1ns/10ps

module game_sequencer #(
    parameter int FRAME_WAIT = maze_pkg::FRAME_WAIT_DEFAULT
) (
    input  logic                  Clk,
    input  logic                  resetn,
    input  logic                  start,
    input  logic                  collision,
    input  logic                  at_goal,
    input  logic                  timeout,
    input  maze_pkg::coord_x_t    player_x,
    input  maze_pkg::coord_y_t    player_y,
    input  logic                  cmd_ready,
    input  logic                  frame_drawn,
    output logic                  cmd_valid,
    output maze_pkg::draw_layer_t cmd_layer,
    output maze_pkg::coord_x_t    cmd_x,
    output maze_pkg::coord_y_t    cmd_y,
    output logic                  playing,
    output logic                  game_over,
    output logic                  game_won
);
    import maze_pkg::*;

    localparam int WAIT_W = $clog2(FRAME_WAIT + 1);

    typedef enum logic [3:0] {
        S_IDLE,
        S_BG,
        S_EXIT,
        S_CHECK,
        S_PLAYER,
        S_SYNC,       // Player sprite still in flight
        S_PAUSE,      // Frame wait
        S_OVER,
        S_OVER_HOLD,
        S_WIN,
        S_WIN_HOLD
    } sequencer_state_t;

    sequencer_state_t  state;
    sequencer_state_t  state_nxt;
    logic [WAIT_W-1:0] wait_cnt;
    coord_x_t          pos_x;
    coord_y_t          pos_y;
    logic              cmd_fire;

    assign cmd_fire = cmd_valid && cmd_ready;

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:      state_nxt = start ? S_BG : S_IDLE;
            S_BG:        state_nxt = cmd_fire ? S_EXIT : S_BG;
            S_EXIT:      state_nxt = cmd_fire ? S_CHECK : S_EXIT;
            S_CHECK:
            begin
                if (collision || timeout)
                    state_nxt = S_OVER;
                else if (at_goal)
                    state_nxt = S_WIN;
                else
                    state_nxt = S_PLAYER;
            end
            S_PLAYER:    state_nxt = cmd_fire ? S_SYNC : S_PLAYER;
            S_SYNC:      state_nxt = frame_drawn ? S_PAUSE : S_SYNC;
            S_PAUSE:     state_nxt = (wait_cnt == WAIT_W'(FRAME_WAIT - 1)) ? S_BG : S_PAUSE;
            S_OVER:      state_nxt = cmd_fire ? S_OVER_HOLD : S_OVER;
            S_WIN:       state_nxt = cmd_fire ? S_WIN_HOLD : S_WIN;
            default:     state_nxt = state; // Hold states
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (!resetn)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge Clk)
    begin
        if (!resetn)
            wait_cnt <= '0;
        else if (state == S_PAUSE)
            wait_cnt <= wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    // Player position sampled once per frame
    always_ff @(posedge Clk)
    begin
        if (state == S_CHECK)
        begin
            pos_x <= player_x;
            pos_y <= player_y;
        end
    end

    always_comb
    begin
        case (state)
            S_EXIT:   cmd_layer = LAYER_EXIT;
            S_PLAYER: cmd_layer = LAYER_PLAYER;
            S_OVER:   cmd_layer = LAYER_OVER;
            S_WIN:    cmd_layer = LAYER_WIN;
            default:  cmd_layer = LAYER_BG;
        endcase
    end

    assign cmd_valid = state inside {S_BG, S_EXIT, S_PLAYER, S_OVER, S_WIN};
    assign cmd_x     = (state == S_PLAYER) ? pos_x : '0;
    assign cmd_y     = (state == S_PLAYER) ? pos_y : '0;

    assign playing   = state inside {S_BG, S_EXIT, S_CHECK, S_PLAYER, S_SYNC, S_PAUSE};
    assign game_over = state inside {S_OVER, S_OVER_HOLD};
    assign game_won  = state inside {S_WIN, S_WIN_HOLD};

endmodule

// ==== design/maze_game_top.sv ====
`timescale 1ns/10ps

module maze_game_top #(
    parameter int TICK_CYCLES = maze_pkg::TICK_CYCLES_DEFAULT,
    parameter int FRAME_WAIT  = maze_pkg::FRAME_WAIT_DEFAULT
) (
    input  logic               Clk,
    input  logic               resetn,
    input  logic               start,
    input  logic               collision,
    input  logic               at_goal,
    input  maze_pkg::coord_x_t player_x,
    input  maze_pkg::coord_y_t player_y,
    input  logic               pix_ready,
    output logic               pix_valid,
    output maze_pkg::coord_x_t pix_x,
    output maze_pkg::coord_y_t pix_y,
    output logic               pix_colour,
    output logic               game_over,
    output logic               game_won,
    output logic               timeout,
    output maze_pkg::seg7_t    seg_units,
    output maze_pkg::seg7_t    seg_tens
);
    import maze_pkg::*;

    logic        cmd_valid;
    logic        cmd_ready;
    draw_layer_t cmd_layer;
    coord_x_t    cmd_x;
    coord_y_t    cmd_y;
    logic        q_valid;
    logic        q_ready;
    draw_layer_t q_layer;
    coord_x_t    q_x;
    coord_y_t    q_y;
    logic        frame_drawn;
    logic        playing;
    seconds_t    seconds;

    game_sequencer #(.FRAME_WAIT(FRAME_WAIT)) i_sequencer (
        .Clk(Clk), .resetn(resetn), .start(start), .collision(collision),
        .at_goal(at_goal), .timeout(timeout), .player_x(player_x), .player_y(player_y),
        .cmd_ready(cmd_ready), .frame_drawn(frame_drawn), .cmd_valid(cmd_valid),
        .cmd_layer(cmd_layer), .cmd_x(cmd_x), .cmd_y(cmd_y), .playing(playing),
        .game_over(game_over), .game_won(game_won)
    );

    draw_queue i_queue (
        .Clk(Clk), .resetn(resetn), .in_valid(cmd_valid), .in_layer(cmd_layer),
        .in_x(cmd_x), .in_y(cmd_y), .out_ready(q_ready), .in_ready(cmd_ready),
        .out_valid(q_valid), .out_layer(q_layer), .out_x(q_x), .out_y(q_y)
    );

    sprite_plotter i_plotter (
        .Clk(Clk), .resetn(resetn), .cmd_valid(q_valid), .cmd_layer(q_layer),
        .cmd_x(q_x), .cmd_y(q_y), .pix_ready(pix_ready), .cmd_ready(q_ready),
        .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour),
        .frame_drawn(frame_drawn)
    );

    countdown_timer #(.TICK_CYCLES(TICK_CYCLES)) i_timer (
        .Clk(Clk), .resetn(resetn), .playing(playing), .seconds(seconds), .timeout(timeout)
    );

    seconds_display i_display (
        .seconds(seconds), .seg_units(seg_units), .seg_tens(seg_tens)
    );

endmodule

// ==== design/maze_pkg.sv ====
package maze_pkg;

    // Pixel and timer value types
    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;
    typedef logic [4:0] seconds_t;
    typedef logic [6:0] seg7_t;       // Active low with bit 0 as segment a

    typedef enum logic [2:0] {
        LAYER_BG,
        LAYER_EXIT,
        LAYER_PLAYER,
        LAYER_OVER,
        LAYER_WIN
    } draw_layer_t;

    // Frame geometry
    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    localparam int PLAYER_SIZE = 20;  // Square sprite
    localparam int EXIT_SIZE   = 10;
    localparam int EXIT_X      = 140; // Exit corner
    localparam int EXIT_Y      = 100;

    // Monochrome colours per layer
    localparam logic BG_COLOUR     = 1'b0;
    localparam logic EXIT_COLOUR   = 1'b1;
    localparam logic PLAYER_COLOUR = 1'b1;
    localparam logic OVER_COLOUR   = 1'b1;
    localparam logic WIN_COLOUR    = 1'b0;

    // Game timing
    localparam int GAME_SECONDS        = 20;
    localparam int TICK_CYCLES_DEFAULT = 50_000_000; // One second at 50 MHz
    localparam int FRAME_WAIT_DEFAULT  = 5_000_000;

    localparam int QUEUE_DEPTH = 4;   // Power of two

endpackage

// ==== design/seconds_display.sv ====
`timescale 1ns/10ps

module seconds_display (
    input  maze_pkg::seconds_t seconds,
    output maze_pkg::seg7_t    seg_units,
    output maze_pkg::seg7_t    seg_tens
);
    import maze_pkg::*;

    logic [3:0] tens_digit;
    logic [3:0] units_digit;

    function automatic seg7_t digit_segments(input logic [3:0] digit);
        seg7_t segs;
        case (digit)
            4'd0:    segs = 7'b100_0000;
            4'd1:    segs = 7'b111_1001;
            4'd2:    segs = 7'b010_0100;
            4'd3:    segs = 7'b011_0000;
            4'd4:    segs = 7'b001_1001;
            4'd5:    segs = 7'b001_0010;
            4'd6:    segs = 7'b000_0010;
            4'd7:    segs = 7'b111_1000;
            4'd8:    segs = 7'b000_0000;
            4'd9:    segs = 7'b001_0000;
            default: segs = 7'b111_1111; // Blank
        endcase
        return segs;
    endfunction

    assign tens_digit  = 4'(seconds / 5'd10);
    assign units_digit = 4'(seconds % 5'd10);

    assign seg_tens  = digit_segments(tens_digit);
    assign seg_units = digit_segments(units_digit);

endmodule

// ==== design/sprite_plotter.sv ====
`timescale 1ns/10ps

module sprite_plotter (
    input  logic                  Clk,
    input  logic                  resetn,
    input  logic                  cmd_valid,
    input  maze_pkg::draw_layer_t cmd_layer,
    input  maze_pkg::coord_x_t    cmd_x,
    input  maze_pkg::coord_y_t    cmd_y,
    input  logic                  pix_ready,
    output logic                  cmd_ready,
    output logic                  pix_valid,
    output maze_pkg::coord_x_t    pix_x,
    output maze_pkg::coord_y_t    pix_y,
    output logic                  pix_colour,
    output logic                  frame_drawn
);
    import maze_pkg::*;

    logic     busy;
    logic     cmd_fire;
    logic     pix_fire;
    logic     last_pix;
    coord_x_t new_x;
    coord_y_t new_y;
    coord_x_t new_last_col;
    coord_y_t new_last_row;
    logic     new_colour;
    coord_x_t base_x;
    coord_y_t base_y;
    coord_x_t last_col;
    coord_y_t last_row;
    coord_x_t col;
    coord_y_t row;
    logic     ends_frame;

    // Rectangle of the incoming command
    always_comb
    begin
        new_x        = '0;
        new_y        = '0;
        new_last_col = coord_x_t'(SCREEN_W - 1);
        new_last_row = coord_y_t'(SCREEN_H - 1);
        case (cmd_layer)
            LAYER_EXIT:
            begin
                new_x        = coord_x_t'(EXIT_X);
                new_y        = coord_y_t'(EXIT_Y);
                new_last_col = coord_x_t'(EXIT_SIZE - 1);
                new_last_row = coord_y_t'(EXIT_SIZE - 1);
                new_colour   = EXIT_COLOUR;
            end
            LAYER_PLAYER:
            begin
                new_x        = cmd_x;
                new_y        = cmd_y;
                new_last_col = coord_x_t'(PLAYER_SIZE - 1);
                new_last_row = coord_y_t'(PLAYER_SIZE - 1);
                new_colour   = PLAYER_COLOUR;
            end
            LAYER_OVER: new_colour = OVER_COLOUR;
            LAYER_WIN:  new_colour = WIN_COLOUR;
            default:    new_colour = BG_COLOUR;
        endcase
    end

    assign cmd_ready = !busy;
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign pix_valid = busy;
    assign pix_fire  = pix_valid && pix_ready;
    assign last_pix  = (col == last_col) && (row == last_row);

    always_ff @(posedge Clk)
    begin
        if (!resetn)
            busy <= 1'b0;
        else if (cmd_fire)
            busy <= 1'b1;
        else if (pix_fire && last_pix)
            busy <= 1'b0;
    end

    always_ff @(posedge Clk)
    begin
        if (cmd_fire)
        begin
            base_x     <= new_x;
            base_y     <= new_y;
            last_col   <= new_last_col;
            last_row   <= new_last_row;
            pix_colour <= new_colour;
            ends_frame <= cmd_layer inside {LAYER_PLAYER, LAYER_OVER, LAYER_WIN};
            col        <= '0;
            row        <= '0;
        end
        else if (pix_fire)
        begin
            if (col == last_col)   // Row major scan
            begin
                col <= '0;
                row <= row + 1'b1;
            end
            else
                col <= col + 1'b1;
        end
    end

    assign pix_x       = base_x + col;
    assign pix_y       = base_y + row;
    assign frame_drawn = pix_fire && last_pix && ends_frame;

endmodule

// ==== tb.f ====
design/maze_pkg.sv
design/game_sequencer.sv
design/draw_queue.sv
design/sprite_plotter.sv
design/countdown_timer.sv
design/seconds_display.sv
design/maze_game_top.sv
tb/maze_game_assert.sv
tb/tb_maze_game.sv

// ==== tb/maze_game_assert.sv ====
`timescale 1ns/10ps

module maze_game_assert (
    input logic               Clk,
    input logic               resetn,
    input logic               pix_valid,
    input logic               pix_ready,
    input maze_pkg::coord_x_t pix_x,
    input maze_pkg::coord_y_t pix_y,
    input logic               pix_colour,
    input logic               game_over,
    input logic               game_won
);
    int failures = 0;

    pix_hold: assert property (@(posedge Clk) disable iff (!resetn)
        pix_valid && !pix_ready |=>
            pix_valid && $stable(pix_x) && $stable(pix_y) && $stable(pix_colour))
    else
    begin
        failures++;
        $error("Pixel changed or was dropped while stalled");
    end

    end_exclusive: assert property (@(posedge Clk) disable iff (!resetn)
        !(game_over && game_won))
    else
    begin
        failures++;
        $error("Game over and game won are high together");
    end

    status_reset: assert property (@(posedge Clk) $rose(resetn) |-> !game_over && !game_won)
    else
    begin
        failures++;
        $error("End status set right after reset");
    end

endmodule

bind maze_game_top maze_game_assert i_assert (
    .Clk(Clk), .resetn(resetn), .pix_valid(pix_valid), .pix_ready(pix_ready),
    .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour),
    .game_over(game_over), .game_won(game_won)
);

// ==== tb/tb_maze_game.sv ====
`timescale 1ns/10ps

module tb_maze_game;
    import maze_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int TICK_CYCLES  = 400;
    localparam int FRAME_WAIT   = 50;
    localparam int GAP_CYCLES   = 20;
    localparam int IDLE_CYCLES  = 200;

    localparam int FULL_PIX   = SCREEN_W * SCREEN_H;
    localparam int EXIT_PIX   = EXIT_SIZE * EXIT_SIZE;
    localparam int PLAYER_PIX = PLAYER_SIZE * PLAYER_SIZE;
    localparam int PLAY_PIX   = 2 * (FULL_PIX + EXIT_PIX) + PLAYER_PIX + FULL_PIX;
    localparam int END_PIX    = FULL_PIX + EXIT_PIX + FULL_PIX;
    localparam int RUN_EXTRA  = RESET_CYCLES + GAP_CYCLES + FRAME_WAIT + IDLE_CYCLES
                              + GAME_SECONDS * TICK_CYCLES;
    // Three runs under random ready at about half rate
    localparam int TEST_CYCLES = PLAY_PIX + 2 * (PLAY_PIX + 2 * END_PIX) + 4 * RUN_EXTRA;
    localparam int WATCHDOG_NS = 4 * TEST_CYCLES * CLK_PERIOD;

    logic        Clk;
    logic        resetn;
    logic        start;
    logic        collision;
    logic        at_goal;
    coord_x_t    player_x;
    coord_y_t    player_y;
    logic        pix_ready;
    logic        pix_valid;
    coord_x_t    pix_x;
    coord_y_t    pix_y;
    logic        pix_colour;
    logic        game_over;
    logic        game_won;
    logic        timeout;
    seg7_t       seg_units;
    seg7_t       seg_tens;

    integer      seed;
    logic        steady_ready;
    int          checks;
    int          errors;
    int          pix_idx;
    int          last_seconds;
    int          sec_steps;
    logic [15:0] exp_pix;
    draw_layer_t exp_layer [$];
    int          exp_x [$];
    int          exp_y [$];

    maze_game_top #(.TICK_CYCLES(TICK_CYCLES), .FRAME_WAIT(FRAME_WAIT)) i_dut (
        .Clk(Clk), .resetn(resetn), .start(start), .collision(collision),
        .at_goal(at_goal), .player_x(player_x), .player_y(player_y), .pix_ready(pix_ready),
        .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour),
        .game_over(game_over), .game_won(game_won), .timeout(timeout),
        .seg_units(seg_units), .seg_tens(seg_tens)
    );

    initial
    begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    function automatic int rect_pixels(input draw_layer_t layer);
        case (layer)
            LAYER_EXIT:   return EXIT_PIX;
            LAYER_PLAYER: return PLAYER_PIX;
            default:      return FULL_PIX;
        endcase
    endfunction

    // Returns {x, y, colour} of pixel idx in a row-major scan of the layer's rectangle
    function automatic logic [15:0] ref_pixel(input draw_layer_t layer, input int cx,
                                              input int cy, input int idx);
        int   w;
        int   x0;
        int   y0;
        logic colour;
        w      = SCREEN_W;
        x0     = 0;
        y0     = 0;
        colour = (layer == LAYER_OVER);   // Full screens lit only for game over
        if (layer == LAYER_EXIT)
        begin
            w      = EXIT_SIZE;
            x0     = EXIT_X;
            y0     = EXIT_Y;
            colour = 1'b1;
        end
        else if (layer == LAYER_PLAYER)
        begin
            w      = PLAYER_SIZE;
            x0     = cx;
            y0     = cy;
            colour = 1'b1;
        end
        return {8'(x0 + idx % w), 7'(y0 + idx / w), colour};
    endfunction

    function automatic seg7_t ref_segments(input int digit);
        string lit;
        seg7_t segs;
        int    i;
        case (digit)
            0:       lit = "abcdef";
            1:       lit = "bc";
            2:       lit = "abdeg";
            3:       lit = "abcdg";
            4:       lit = "bcfg";
            5:       lit = "acdfg";
            6:       lit = "acdefg";
            7:       lit = "abc";
            8:       lit = "abcdefg";
            9:       lit = "abcdfg";
            default: lit = "";
        endcase
        segs = '1;
        for (i = 0; i < lit.len(); i++)
            segs[lit[i] - "a"] = 1'b0;
        return segs;
    endfunction

    task automatic queue_cmd(input draw_layer_t layer, input int cx, input int cy);
        exp_layer.push_back(layer);
        exp_x.push_back(cx);
        exp_y.push_back(cy);
    endtask

    task automatic apply_reset();
        @(posedge Clk);
        resetn    <= 1'b0;
        start     <= 1'b0;
        collision <= 1'b0;
        at_goal   <= 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        resetn <= 1'b1;
        @(posedge Clk);
        check_value("pix_valid", pix_valid, 0);
        check_value("game_over", game_over, 0);
        check_value("game_won", game_won, 0);
        check_value("timeout", timeout, 0);
        check_value("seconds", i_dut.seconds, GAME_SECONDS);
    endtask

    // One game from reset to its end screen
    task automatic play_run(input logic steady, input logic goal, input logic hit);
        int px;
        int py;
        @(negedge Clk);
        px = $unsigned($random(seed)) % (SCREEN_W - PLAYER_SIZE + 1);
        py = $unsigned($random(seed)) % (SCREEN_H - PLAYER_SIZE + 1);
        steady_ready = steady;
        exp_layer.delete();
        exp_x.delete();
        exp_y.delete();
        apply_reset();
        player_x  <= coord_x_t'(px);
        player_y  <= coord_y_t'(py);
        at_goal   <= goal;
        collision <= hit;
        repeat (GAP_CYCLES) @(posedge Clk);   // Nothing may be drawn yet
        queue_cmd(LAYER_BG, 0, 0);
        queue_cmd(LAYER_EXIT, 0, 0);
        if (hit)
            queue_cmd(LAYER_OVER, 0, 0);
        else if (goal)
            queue_cmd(LAYER_WIN, 0, 0);
        else
        begin
            queue_cmd(LAYER_PLAYER, px, py);
            queue_cmd(LAYER_BG, 0, 0);
            queue_cmd(LAYER_EXIT, 0, 0);
            queue_cmd(LAYER_OVER, 0, 0);   // Timer runs out during the first frame
        end
        start <= 1'b1;
        @(posedge Clk);
        start <= 1'b0;
        while (exp_layer.size() != 0)
            @(posedge Clk);
        repeat (IDLE_CYCLES) @(posedge Clk);
        check_value("game_over", game_over, hit || !goal);
        check_value("game_won", game_won, goal && !hit);
        if (!goal && !hit)
        begin
            check_value("timeout", timeout, 1);
            check_value("seconds_steps", sec_steps, GAME_SECONDS);
        end
    endtask

    // Pixel sink
    always @(posedge Clk)
    begin
        if (steady_ready)
            pix_ready <= 1'b1;
        else
            pix_ready <= (($random(seed) & 32'd1) != 0);
    end

    // Pixel compare against the expected command sequence
    always @(posedge Clk)
    begin
        if (!resetn)
            pix_idx = 0;
        else if (pix_valid && pix_ready)
        begin
            if (exp_layer.size() == 0)
            begin
                errors++;
                $display("Unexpected pixel at %0t: x %0d y %0d drawn with no command pending",
                         $time, pix_x, pix_y);
            end
            else
            begin
                exp_pix = ref_pixel(exp_layer[0], exp_x[0], exp_y[0], pix_idx);
                check_value("pix_x", pix_x, exp_pix[15:8]);
                check_value("pix_y", pix_y, exp_pix[7:1]);
                check_value("pix_colour", pix_colour, exp_pix[0]);
                if (pix_idx + 1 == rect_pixels(exp_layer[0]))
                begin
                    void'(exp_layer.pop_front());
                    void'(exp_x.pop_front());
                    void'(exp_y.pop_front());
                    pix_idx = 0;
                end
                else
                    pix_idx++;
            end
        end
    end

    // Seconds display and timeout monitor
    always @(posedge Clk)
    begin
        if (!resetn)
        begin
            last_seconds = GAME_SECONDS;
            sec_steps    = 0;
        end
        else
        begin
            check_value("seg_tens", seg_tens, ref_segments(i_dut.seconds / 10));
            check_value("seg_units", seg_units, ref_segments(i_dut.seconds % 10));
            check_value("timeout", timeout, i_dut.seconds == 0);
            if (i_dut.seconds != last_seconds)
            begin
                check_value("seconds", i_dut.seconds, last_seconds - 1);
                sec_steps++;
                last_seconds = i_dut.seconds;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t: the games did not reach their end screens", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        seed         = 77620;
        steady_ready = 1'b1;
        checks       = 0;
        errors       = 0;
        resetn       = 1'b0;
        start        = 1'b0;
        collision    = 1'b0;
        at_goal      = 1'b0;
        player_x     = '0;
        player_y     = '0;
        pix_ready    = 1'b0;

        play_run(1'b1, 1'b0, 1'b0);   // Steady sink where the timer ends the game
        play_run(1'b0, 1'b0, 1'b0);
        play_run(1'b0, 1'b1, 1'b0);
        play_run(1'b0, 1'b1, 1'b1);   // Collision beats goal

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_dut.i_assert.failures);
        if (errors == 0 && i_dut.i_assert.failures == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
